// ==== riscv_pkg.sv ====
`default_nettype none

package riscv_pkg;

    typedef enum logic [6:0] {
        op_load   = 7'b0000011,           // lw.
        op_imm    = 7'b0010011,           // addi.
        op_store  = 7'b0100011,           // sw.
        op_rtype  = 7'b0110011,           // add, sub, or, and, xor, sll.
        op_branch = 7'b1100011,           // beq.
        op_jal    = 7'b1101111            // jal.
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_or,
        alu_and,
        alu_xor,
        alu_sll
    } alu_op_e;

    typedef enum logic {
        alu_src_reg,                      // second operand from rs2.
        alu_src_imm                       // second operand from the immediate.
    } alu_src_e;

    typedef enum logic [1:0] {
        res_alu_out,
        res_read_data,
        res_pc_plus_4
    } result_src_e;

    typedef enum logic [1:0] {
        imm_i,
        imm_s,
        imm_b,
        imm_j
    } imm_src_e;

    typedef struct packed {
        logic        reg_we;
        logic        mem_we;
        alu_src_e    alu_src;
        result_src_e result_src;
        logic        pc_src;              // 1 selects pc + imm.
        imm_src_e    imm_src;
        alu_op_e     alu_op;
        logic        illegal;             // opcode outside the supported subset.
    } ctrl_t;

    typedef struct packed {
        logic [31:0] data;
        logic        last;                // final word of the program.
    } prog_word_t;

    typedef struct packed {
        logic [31:0] addr;                // word address, not byte address.
        logic [31:0] data;
    } store_rec_t;

endpackage

`default_nettype wire

// ==== alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu import riscv_pkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  alu_op_e     op,
    output logic [31:0] y,
    output logic        zero
);
    always_comb begin
        case (op)
            alu_add: y = a + b;
            alu_sub: y = a - b;
            alu_or:  y = a | b;
            alu_and: y = a & b;
            alu_xor: y = a ^ b;
            alu_sll: y = a << b[4:0];                         // shamt is 5 bits.
            default: y = '0;
        endcase
    end

    assign zero = (y == 32'd0);                               // drives beq.
endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  logic        clk,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic [31:0] wd,
    input  logic        we,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);
    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we && rd != 5'd0) begin                           // x0 never written.
            regs[rd] <= wd;
        end
    end

    // reads are combinational, x0 forced to zero.
    assign rd1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
    assign rd2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];
endmodule

`default_nettype wire

// ==== controller.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_dec import riscv_pkg::*; (
    input  opcode_e    op,
    input  logic [2:0] func3,
    input  logic [6:0] func7,
    output alu_op_e    alu_op
);
    alu_op_e r_op;                                            // operation for r-type.

    always_comb begin
        case (func3)
            3'b000:  r_op = func7[5] ? alu_sub : alu_add;     // bit 30 marks sub.
            3'b110:  r_op = alu_or;
            3'b111:  r_op = alu_and;
            3'b100:  r_op = alu_xor;
            3'b001:  r_op = alu_sll;
            default: r_op = alu_add;
        endcase
    end

    always_comb begin
        case (op)
            op_rtype:  alu_op = r_op;
            op_branch: alu_op = alu_sub;                      // beq compares by subtracting.
            default:   alu_op = alu_add;                      // address and addi sums.
        endcase
    end
endmodule

module controller import riscv_pkg::*; (
    input  logic [31:0] instr,
    input  logic        alu_zero,
    output ctrl_t       ctrl
);
    opcode_e op;
    alu_op_e alu_op;

    assign op = opcode_e'(instr[6:0]);

    alu_dec u_alu_dec (
        .op     (op),
        .func3  (instr[14:12]),
        .func7  (instr[31:25]),
        .alu_op (alu_op)
    );

    always_comb begin
        ctrl        = '0;                                     // no writes unless decoded.
        ctrl.alu_op = alu_op;
        case (op)
            op_load: begin
                ctrl.reg_we     = 1'b1;
                ctrl.alu_src    = alu_src_imm;
                ctrl.result_src = res_read_data;
                ctrl.imm_src    = imm_i;
            end
            op_imm: begin
                ctrl.reg_we  = 1'b1;
                ctrl.alu_src = alu_src_imm;
                ctrl.imm_src = imm_i;                         // result from alu.
            end
            op_store: begin
                ctrl.mem_we  = 1'b1;
                ctrl.alu_src = alu_src_imm;
                ctrl.imm_src = imm_s;
            end
            op_rtype: ctrl.reg_we = 1'b1;                     // reg operands, alu result.
            op_branch: begin
                ctrl.pc_src  = alu_zero;                      // taken when equal.
                ctrl.imm_src = imm_b;
            end
            op_jal: begin
                ctrl.reg_we     = 1'b1;
                ctrl.result_src = res_pc_plus_4;              // link address.
                ctrl.pc_src     = 1'b1;
                ctrl.imm_src    = imm_j;
            end
            default: ctrl.illegal = 1'b1;                     // stops the core.
        endcase
    end
endmodule

`default_nettype wire

// ==== datapath.sv ====
`timescale 1ns/100ps
`default_nettype none

module datapath import riscv_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        run,
    input  logic        stall,
    input  logic [31:0] instr,
    input  ctrl_t       ctrl,
    input  logic [31:0] read_data,
    output logic [31:0] pc,
    output logic [31:0] alu_out,
    output logic [31:0] write_data,
    output logic        alu_zero
);
    logic [31:0] imm;
    logic [31:0] pc_plus_4;
    logic [31:0] pc_next;
    logic [31:0] src_a;
    logic [31:0] src_b;
    logic [31:0] result;
    logic        advance;                                     // instruction retires this cycle.

    assign advance   = run && !stall && !ctrl.illegal;
    assign pc_plus_4 = pc + 32'd4;
    assign pc_next   = ctrl.pc_src ? pc + imm : pc_plus_4;

    always_comb begin
        case (ctrl.imm_src)
            imm_i:   imm = {{20{instr[31]}}, instr[31:20]};
            imm_s:   imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            imm_b:   imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            imm_j:   imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || !run) begin
            pc <= '0;                                         // next program starts at 0.
        end else if (advance) begin
            pc <= pc_next;
        end
    end

    reg_file u_reg_file (
        .clk (clk),
        .rs1 (instr[19:15]),
        .rs2 (instr[24:20]),
        .rd  (instr[11:7]),
        .wd  (result),
        .we  (ctrl.reg_we && advance),                        // held during a stall.
        .rd1 (src_a),
        .rd2 (write_data)
    );

    assign src_b = (ctrl.alu_src == alu_src_imm) ? imm : write_data;

    alu u_alu (
        .a    (src_a),
        .b    (src_b),
        .op   (ctrl.alu_op),
        .y    (alu_out),
        .zero (alu_zero)
    );

    always_comb begin
        case (ctrl.result_src)
            res_read_data: result = read_data;
            res_pc_plus_4: result = pc_plus_4;                // jal link.
            default:       result = alu_out;
        endcase
    end

    // a taken jump or branch must land on a word boundary.
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        advance && ctrl.pc_src |=> pc[1:0] == 2'b00);
endmodule

`default_nettype wire

// ==== program_loader.sv ====
`timescale 1ns/100ps
`default_nettype none

module program_loader import riscv_pkg::*; #(
    parameter int IMEM_WORDS = 64
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        prog_valid,
    input  prog_word_t  prog,
    input  logic [31:0] pc,
    input  logic        illegal,
    output logic        prog_ready,
    output logic [31:0] instr,
    output logic        run,
    output logic        done
);
    localparam int AW = $clog2(IMEM_WORDS);

    typedef enum logic [1:0] {
        st_idle,
        st_load,
        st_run,
        st_done
    } state_e;

    state_e        state;
    logic [AW-1:0] wr_addr;                                   // next free word while loading.
    logic [AW-1:0] wr_idx;
    logic          xfer;
    logic [31:0]   imem [IMEM_WORDS];

    assign prog_ready = (state != st_run);                    // no loading while the core runs.
    assign xfer       = prog_valid && prog_ready;
    assign wr_idx     = (state == st_load) ? wr_addr : '0;    // a fresh load starts at 0.
    assign run        = (state == st_run);
    assign done       = (state == st_done);
    assign instr      = imem[pc[AW+1:2]];

    always_ff @(posedge clk) begin
        if (xfer) begin
            imem[wr_idx] <= prog.data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= st_idle;
            wr_addr <= '0;
        end else begin
            if (xfer) begin
                wr_addr <= wr_idx + 1'b1;
                state   <= prog.last ? st_run : st_load;      // last word launches the core.
            end else if (state == st_run && illegal) begin
                state <= st_done;                             // halt on unknown opcode.
            end
        end
    end

    a_start: assert property (@(posedge clk) disable iff (rst)
        xfer && prog.last |=> run && pc == 32'd0);
    a_no_load_in_run: assert property (@(posedge clk) disable iff (rst)
        run |-> !(prog_valid && prog_ready));
endmodule

`default_nettype wire

// ==== data_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_mem import riscv_pkg::*; #(
    parameter int DMEM_WORDS = 64
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        run,
    input  ctrl_t       ctrl,
    input  logic [31:0] alu_out,
    input  logic [31:0] write_data,
    input  logic        store_ready,
    output logic [31:0] read_data,
    output logic        store_valid,
    output store_rec_t  store,
    output logic        stall
);
    localparam int AW = $clog2(DMEM_WORDS);

    logic [31:0]   dmem [DMEM_WORDS];
    logic [AW-1:0] idx;

    assign idx         = alu_out[AW+1:2];                     // word addressed.
    assign read_data   = dmem[idx];
    assign store_valid = run && ctrl.mem_we;
    assign store.addr  = {2'b00, alu_out[31:2]};
    assign store.data  = write_data;
    assign stall       = store_valid && !store_ready;         // core waits for the trace.

    always_ff @(posedge clk) begin
        if (store_valid && store_ready) begin
            dmem[idx] <= write_data;                          // write with the trace transfer.
        end
    end

    a_store_stable: assert property (@(posedge clk) disable iff (rst)
        store_valid && !store_ready |=> store_valid && $stable(store));
endmodule

`default_nettype wire

// ==== cpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_top import riscv_pkg::*; #(
    parameter int IMEM_WORDS = 64,
    parameter int DMEM_WORDS = 64
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       prog_valid,
    input  prog_word_t prog,
    output logic       prog_ready,
    output logic       store_valid,
    output store_rec_t store,
    input  logic       store_ready,
    output logic       done
);
    logic [31:0] instr;
    logic [31:0] pc;
    logic [31:0] alu_out;
    logic [31:0] write_data;
    logic [31:0] read_data;
    logic        run;
    logic        stall;
    logic        alu_zero;
    ctrl_t       ctrl;

    program_loader #(.IMEM_WORDS(IMEM_WORDS)) u_loader (
        .clk(clk), .rst(rst), .prog_valid(prog_valid), .prog(prog),
        .pc(pc), .illegal(ctrl.illegal), .prog_ready(prog_ready),
        .instr(instr), .run(run), .done(done)
    );

    controller u_ctrl (.instr(instr), .alu_zero(alu_zero), .ctrl(ctrl));

    datapath u_dp (
        .clk(clk), .rst(rst), .run(run), .stall(stall), .instr(instr),
        .ctrl(ctrl), .read_data(read_data), .pc(pc), .alu_out(alu_out),
        .write_data(write_data), .alu_zero(alu_zero)
    );

    data_mem #(.DMEM_WORDS(DMEM_WORDS)) u_dmem (
        .clk(clk), .rst(rst), .run(run), .ctrl(ctrl), .alu_out(alu_out),
        .write_data(write_data), .store_ready(store_ready), .read_data(read_data),
        .store_valid(store_valid), .store(store), .stall(stall)
    );
endmodule

`default_nettype wire

// ==== cpu_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_checker import riscv_pkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       store_valid,
    input logic       store_ready,
    input store_rec_t store,
    input logic       done
);
    store_rec_t    exp_q [$];                                 // stores still to come.
    reg [8*32-1:0] test_name      = "none";
    int            store_idx      = 0;                        // position within the test.
    int            test_errors    = 0;
    int            total_errors   = 0;
    int            tests_run      = 0;
    int            tests_failed   = 0;
    int            stores_checked = 0;
    logic          done_q         = 1'b0;

    task automatic start_test(input reg [8*32-1:0] name);
        test_name   = name;
        test_errors = 0;
        store_idx   = 0;
        exp_q.delete();
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
        store_rec_t rec;
        rec.addr = addr;
        rec.data = data;
        exp_q.push_back(rec);
    endtask

    task automatic check_store(input store_rec_t got);
        store_rec_t want;
        if (exp_q.size() == 0) begin
            $display("test %0s wrote an extra store to word %h with data %h",
                     test_name, got.addr, got.data);
            test_errors++;
        end else begin
            want = exp_q.pop_front();
            stores_checked++;
            if (got !== want) begin
                $display("FAILED %0t: test %0s store %0d expected [%h] %h, got [%h] %h",
                         $time, test_name, store_idx, want.addr, want.data, got.addr, got.data);
                test_errors++;
            end
        end
        store_idx++;
    endtask

    task automatic finish_test();
        if (exp_q.size() != 0) begin
            $display("test %0s halted with %0d expected stores missing", test_name, exp_q.size());
            test_errors += exp_q.size();
        end
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %0s: passed, %0d stores", test_name, store_idx);
        end else begin
            tests_failed++;
            $display("test %0s: failed with %0d errors", test_name, test_errors);
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            done_q <= 1'b0;
        end else begin
            done_q <= done;
            if (store_valid && store_ready) begin
                check_store(store);                           // accepted trace record.
            end
            if (done && !done_q) begin
                finish_test();                                // core halted.
            end
        end
    end
endmodule

`default_nettype wire

// ==== tb_cpu.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_cpu import riscv_pkg::*; ();
    localparam int LOAD_TIMEOUT = 100;                        // cycles per handshake.
    localparam int RUN_TIMEOUT  = 5000;                       // cycles for one program.
    localparam int MAX_WORDS    = 64;

    logic          clk         = 1'b0;
    logic          rst         = 1'b1;
    logic          prog_valid  = 1'b0;
    prog_word_t    prog        = '0;
    logic          store_ready = 1'b1;
    logic          prog_ready;
    logic          store_valid;
    store_rec_t    store;
    logic          done;
    logic          rand_ready  = 1'b0;                        // random store_ready this test.
    logic [31:0]   prog_mem [MAX_WORDS];
    int            n_words;
    int            fd;
    int            tests_loaded;
    bit            aborted;
    bit            found;
    reg [8*32-1:0] test_name;
    int unsigned   seed_val;

    always #10 clk = ~clk;                                    // 20 ns period.

    cpu_top #(.IMEM_WORDS(64), .DMEM_WORDS(64)) UUT (
        .clk(clk), .rst(rst), .prog_valid(prog_valid), .prog(prog),
        .prog_ready(prog_ready), .store_valid(store_valid), .store(store),
        .store_ready(store_ready), .done(done)
    );

    cpu_checker u_checker (
        .clk(clk), .rst(rst), .store_valid(store_valid), .store_ready(store_ready),
        .store(store), .done(done)
    );

    // the random draws come from this process, so the seed goes here.
    initial begin
        seed_val = $urandom(32'hf97);
        forever begin
            @(negedge clk);
            store_ready <= rand_ready ? ($urandom % 2 == 0) : 1'b1;  // trace back-pressure.
        end
    end

    // one block of the stim file: test header, program words, expected stores.
    task automatic read_block(output bit got_test);
        reg [8*32-1:0]  tok;
        reg [8*256-1:0] skip_line;
        logic [31:0]    addr;
        logic [31:0]    data;
        int             cnt;
        int             mode;
        int             r;
        got_test = 1'b0;
        n_words  = 0;
        r = $fscanf(fd, "%s", tok);
        while (r == 1 && tok != "end" && !aborted) begin
            if (tok == "#") begin
                r = $fgets(skip_line, fd);                    // column notes.
            end else if (tok == "test") begin
                r = $fscanf(fd, "%s %d", test_name, mode);
                rand_ready = (mode != 0);
                u_checker.start_test(test_name);
                got_test = 1'b1;
            end else if (tok == "p") begin
                r = $fscanf(fd, "%d", cnt);
                for (int i = 0; i < cnt; i++) begin
                    r = $fscanf(fd, "%h", data);
                    if (n_words < MAX_WORDS) begin
                        prog_mem[n_words] = data;
                        n_words++;
                    end
                end
            end else if (tok == "s") begin
                r = $fscanf(fd, "%d", cnt);
                for (int i = 0; i < cnt; i++) begin
                    r = $fscanf(fd, "%h %h", addr, data);
                    u_checker.expect_store(addr, data);       // word address and data.
                end
            end else begin
                $display("unknown token %0s in the stimulus file", tok);
                aborted = 1'b1;
            end
            r = $fscanf(fd, "%s", tok);
        end
    endtask

    task automatic load_program();
        int waited;
        for (int i = 0; i < n_words && !aborted; i++) begin
            @(negedge clk);
            prog_valid = 1'b1;
            prog.data  = prog_mem[i];
            prog.last  = (i == n_words - 1);                  // last word starts the core.
            waited     = 0;
            while (!prog_ready && waited < LOAD_TIMEOUT) begin
                @(negedge clk);
                waited++;
            end
            if (!prog_ready) begin
                $display("timeout: loader never accepted word %0d of test %0s", i, test_name);
                aborted = 1'b1;
            end
        end
        @(negedge clk);
        prog_valid = 1'b0;
    endtask

    task automatic wait_done();
        int waited;
        waited = 0;
        while (!done && waited < RUN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            $display("timeout: test %0s never raised done", test_name);
            aborted = 1'b1;
        end
        waited = 0;
        while (!aborted && u_checker.tests_run < tests_loaded && waited < LOAD_TIMEOUT) begin
            @(negedge clk);                                   // checker reports on the next edge.
            waited++;
        end
        if (!aborted && u_checker.tests_run < tests_loaded) begin
            $display("timeout: checker never reported test %0s", test_name);
            aborted = 1'b1;
        end
    endtask

    initial begin
        aborted      = 1'b0;
        tests_loaded = 0;
        fd = $fopen("cpu_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open cpu_stim.txt");
            aborted = 1'b1;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst   = 1'b0;
        found = 1'b1;
        while (!aborted && found) begin
            read_block(found);
            if (found && !aborted) begin
                tests_loaded++;
                load_program();                               // reloads run without reset.
                if (!aborted) begin
                    wait_done();
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("tests %0d of %0d reported, %0d failed, %0d stores checked, %0d errors",
                 u_checker.tests_run, tests_loaded, u_checker.tests_failed,
                 u_checker.stores_checked, u_checker.total_errors);
        if (!aborted && tests_loaded > 0 && u_checker.total_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end
endmodule

`default_nettype wire

// ==== cpu_stim.txt ====
# test <name> <ready mode: 0 always ready, 1 random>, then p <n> <n instruction words>
# and s <n> <n pairs of word address and data>, hex throughout; end closes the test
test rtype 0
p 9 00C00093 00A00113 002081B3 40208233 0020E2B3 0020F333 0020C3B3 00209433 401104B3
p 8 00302023 00402223 00502423 00602623 00702823 00802A23 00902C23 00000000
s 4 00000000 00000016 00000001 00000002 00000002 0000000E 00000003 00000008
s 3 00000004 00000006 00000005 00003000 00000006 FFFFFFFE
end
test loadstore 0
p 10 12300093 02102423 02802103 FF000193 00310233 02402623 03000293 FF82A303 0062A023 00000000
s 3 0000000A 00000123 0000000B 00000113 0000000C 00000123
end
test branch 0
p 9 00500093 00500113 00700193 00208463 02302A23 00308463 02102C23 02302E23 00000000
s 2 0000000E 00000005 0000000F 00000007
end
test jump 0
p 9 00900093 00C002EF 04102023 04102223 04502423 0080036F 04102023 04602623 00000000
s 2 00000012 00000008 00000013 00000018
end
test rtype_random 1
p 9 00C00093 00A00113 002081B3 40208233 0020E2B3 0020F333 0020C3B3 00209433 401104B3
p 8 00302023 00402223 00502423 00602623 00702823 00802A23 00902C23 00000000
s 4 00000000 00000016 00000001 00000002 00000002 0000000E 00000003 00000008
s 3 00000004 00000006 00000005 00003000 00000006 FFFFFFFE
end
test reload 0
p 4 05500513 04A02823 04A02A23 00000000
s 2 00000014 00000055 00000015 00000055
end

// ==== sources.f ====
riscv_pkg.sv
alu.sv
reg_file.sv
controller.sv
datapath.sv
program_loader.sv
data_mem.sv
cpu_top.sv
cpu_checker.sv
tb_cpu.sv

// ==== Bender.yml ====
package:
  name: rv32_store_trace_core

sources:
  - riscv_pkg.sv
  - alu.sv
  - reg_file.sv
  - controller.sv
  - datapath.sv
  - program_loader.sv
  - data_mem.sv
  - cpu_top.sv
  - target: simulation
    files:
      - cpu_checker.sv
      - tb_cpu.sv
